// File: source/fir_regmap_pkg.sv
package fir_regmap_pkg;

    // lite address space
    localparam int ADDR_W = 12;

    localparam logic [ADDR_W-1:0] ADDR_CTRL     = 12'h000;  // start, done, idle
    localparam logic [ADDR_W-1:0] ADDR_LEN      = 12'h010;  // samples per run
    localparam logic [ADDR_W-1:0] ADDR_TAP_BASE = 12'h080;  // tap i at base + 4*i

    // control register fields
    localparam int CTRL_START_BIT = 0;

    // one write as seen by the decoder
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [31:0]       data;
    } lite_wr_t;

endpackage

// File: source/fir_dsp_pkg.sv
package fir_dsp_pkg;

    // stream word width
    localparam int DATA_W = 32;

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [DATA_W-1:0] coef_t;
    typedef logic signed [DATA_W-1:0] acc_t;    // wraps, no guard bits

    // coefficient store write, index covers up to 32 taps
    typedef struct packed {
        logic [4:0] index;
        coef_t      value;
    } coef_wr_t;

    // one filter output on its way to the stream
    typedef struct packed {
        acc_t value;
        logic last;   // data_len-th result of the run
    } result_t;

endpackage

// File: source/fir_word_store.sv
`timescale 1ns/1ps

module fir_word_store #(
    parameter int  DEPTH  = 11,
    parameter type word_t = logic [31:0]
) (
    input  logic                     axis_clk,
    input  logic                     axis_rst_n,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_t                    rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // combinational read, same cycle as address
    assign rdata = mem[raddr];

endmodule

// File: source/fir_ctrl_decode.sv
`timescale 1ns/1ps

module fir_ctrl_decode #(
    parameter int N_TAPS = 11
) (
    input  logic                     axis_clk,
    input  logic                     axis_rst_n,
    input  logic                     wr_valid,
    input  fir_regmap_pkg::lite_wr_t wr,
    output logic                     wr_ack,
    output logic                     coef_we,
    output fir_dsp_pkg::coef_wr_t    coef_wr,
    output logic [31:0]              data_len,
    output logic                     start,
    input  logic                     run_done,
    output logic                     ap_idle
);

    logic                              accept;
    logic                              hit_ctrl;
    logic                              hit_len;
    logic                              hit_tap;
    logic [fir_regmap_pkg::ADDR_W-1:0] tap_off;

    // one write per ack pulse
    assign accept = wr_valid && !wr_ack;

    assign tap_off = wr.addr - fir_regmap_pkg::ADDR_TAP_BASE;

    // configuration only while idle
    assign hit_ctrl = accept && ap_idle && (wr.addr == fir_regmap_pkg::ADDR_CTRL);
    assign hit_len  = accept && ap_idle && (wr.addr == fir_regmap_pkg::ADDR_LEN);
    assign hit_tap  = accept && ap_idle
                      && (wr.addr >= fir_regmap_pkg::ADDR_TAP_BASE)
                      && (tap_off[fir_regmap_pkg::ADDR_W-1:2] < N_TAPS);

    assign coef_we       = hit_tap;
    assign coef_wr.index = tap_off[6:2];   // word offset from tap base
    assign coef_wr.value = wr.data;

    // awready/wready pulse
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= accept;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_len <= '0;
        end else if (hit_len) begin
            data_len <= wr.data;
        end
    end

    // run state, idle until start is written
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            start   <= 1'b0;
            ap_idle <= 1'b1;
        end else begin
            start <= 1'b0;
            if (hit_ctrl && wr.data[fir_regmap_pkg::CTRL_START_BIT]) begin
                start   <= 1'b1;
                ap_idle <= 1'b0;
            end else if (run_done) begin
                ap_idle <= 1'b1;   // last result has left the block
            end
        end
    end

endmodule

// File: source/fir_mac_execute.sv
`timescale 1ns/1ps

module fir_mac_execute #(
    parameter int N_TAPS = 11
) (
    input  logic                      axis_clk,
    input  logic                      axis_rst_n,
    input  logic                      start,
    input  logic [31:0]               data_len,
    input  logic                      ss_tvalid,
    input  fir_dsp_pkg::sample_t      ss_tdata,
    output logic                      ss_tready,
    output logic                      hist_we,
    output logic [$clog2(N_TAPS)-1:0] hist_waddr,
    output fir_dsp_pkg::sample_t      hist_wdata,
    output logic [$clog2(N_TAPS)-1:0] hist_raddr,
    input  fir_dsp_pkg::sample_t      hist_rdata,
    output logic [$clog2(N_TAPS)-1:0] coef_raddr,
    input  fir_dsp_pkg::coef_t        coef_rdata,
    output logic                      res_valid,
    output fir_dsp_pkg::result_t      res,
    input  logic                      res_ready
);

    localparam int               IDX_W    = $clog2(N_TAPS);
    localparam logic [IDX_W-1:0] LAST_TAP = IDX_W'(N_TAPS - 1);

    typedef enum logic [1:0] {
        S_WAIT,
        S_ACC,
        S_HOLD
    } state_t;

    state_t            state;
    logic              running;
    logic              take;
    logic [31:0]       taken;      // samples accepted this run
    logic [IDX_W-1:0]  wptr;
    logic [IDX_W-1:0]  newest;     // slot of the sample being filtered
    logic [IDX_W-1:0]  tap;
    fir_dsp_pkg::acc_t acc;
    fir_dsp_pkg::acc_t term;

    assign ss_tready = running && (state == S_WAIT) && (taken < data_len);
    assign take      = ss_tvalid && ss_tready;

    assign hist_we    = take;
    assign hist_waddr = wptr;
    assign hist_wdata = ss_tdata;

    // tap i reads the sample i places back, modulo N_TAPS
    assign coef_raddr = tap;
    assign hist_raddr = (tap <= newest) ? (newest - tap)
                                        : (newest + IDX_W'(N_TAPS) - tap);

    // reaches before the first sample of the run count as zero
    assign term = (32'(tap) < taken) ? (coef_rdata * hist_rdata) : '0;

    assign res_valid = (state == S_HOLD);
    assign res.value = acc;
    assign res.last  = (taken == data_len);

    // sequencer: wait sample, one tap per clock, hold result
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state   <= S_WAIT;
            running <= 1'b0;
            taken   <= '0;
            wptr    <= '0;
            newest  <= '0;
            tap     <= '0;
        end else if (start) begin
            state   <= S_WAIT;
            running <= 1'b1;
            taken   <= '0;
            wptr    <= '0;
            newest  <= '0;
            tap     <= '0;
        end else begin
            case (state)
                S_WAIT: begin
                    if (take) begin
                        state  <= S_ACC;
                        newest <= wptr;
                        wptr   <= (wptr == LAST_TAP) ? '0 : wptr + 1'b1;
                        taken  <= taken + 32'd1;
                        tap    <= '0;
                    end
                end
                S_ACC: begin
                    tap <= tap + 1'b1;
                    if (tap == LAST_TAP) begin
                        state <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    if (res_ready) begin
                        state <= S_WAIT;
                        if (res.last) begin
                            running <= 1'b0;   // no more input this run
                        end
                    end
                end
                default: state <= S_WAIT;
            endcase
        end
    end

    // accumulator, cleared as each sample is taken
    always_ff @(posedge axis_clk) begin
        if (take) begin
            acc <= '0;
        end else if (state == S_ACC) begin
            acc <= acc + term;
        end
    end

endmodule

// File: source/fir_result_stream.sv
`timescale 1ns/1ps

module fir_result_stream (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  logic                 res_valid,
    input  fir_dsp_pkg::result_t res,
    output logic                 res_ready,
    output logic                 sm_tvalid,
    output fir_dsp_pkg::acc_t    sm_tdata,
    output logic                 sm_tlast,
    input  logic                 sm_tready,
    output logic                 run_done
);

    logic                 full;
    logic                 load;
    fir_dsp_pkg::result_t held;

    // free, or emptied this cycle
    assign res_ready = !full || sm_tready;
    assign load      = res_valid && res_ready;

    assign sm_tvalid = full;
    assign sm_tdata  = held.value;
    assign sm_tlast  = full && held.last;

    // last result accepted downstream
    assign run_done = full && sm_tready && held.last;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (sm_tready) begin
            full <= 1'b0;
        end
    end

    // held under back-pressure
    always_ff @(posedge axis_clk) begin
        if (load) begin
            held <= res;
        end
    end

endmodule

// File: source/fir_top.sv
`timescale 1ns/1ps

module fir_top #(
    parameter int N_TAPS = 11
) (
    input  logic                                axis_clk,
    input  logic                                axis_rst_n,
    input  logic                                awvalid,
    input  logic [fir_regmap_pkg::ADDR_W-1:0]   awaddr,
    output logic                                awready,
    input  logic                                wvalid,
    input  logic [31:0]                         wdata,
    output logic                                wready,
    input  logic                                ss_tvalid,
    input  fir_dsp_pkg::sample_t                ss_tdata,
    output logic                                ss_tready,
    output logic                                sm_tvalid,
    output fir_dsp_pkg::acc_t                   sm_tdata,
    output logic                                sm_tlast,
    input  logic                                sm_tready,
    output logic                                ap_idle
);

    localparam int IDX_W = $clog2(N_TAPS);

    logic                     wr_valid;
    logic                     wr_ack;
    fir_regmap_pkg::lite_wr_t lite_wr;
    logic                     coef_we;
    fir_dsp_pkg::coef_wr_t    coef_wr;
    logic [31:0]              data_len;
    logic                     start;
    logic                     run_done;
    logic                     hist_we;
    logic [IDX_W-1:0]         hist_waddr;
    fir_dsp_pkg::sample_t     hist_wdata;
    logic [IDX_W-1:0]         hist_raddr;
    fir_dsp_pkg::sample_t     hist_rdata;
    logic [IDX_W-1:0]         coef_raddr;
    fir_dsp_pkg::coef_t       coef_rdata;
    logic                     res_valid;
    logic                     res_ready;
    fir_dsp_pkg::result_t     res;

    assign wr_valid = awvalid && wvalid;
    assign lite_wr  = '{addr: awaddr, data: wdata};
    assign awready  = wr_ack;   // address and data acked together
    assign wready   = wr_ack;

    fir_ctrl_decode #(.N_TAPS(N_TAPS)) fir_ctrl_decode_i (
        .axis_clk, .axis_rst_n, .wr_valid, .wr(lite_wr), .wr_ack,
        .coef_we, .coef_wr, .data_len, .start, .run_done, .ap_idle
    );

    fir_word_store #(.DEPTH(N_TAPS), .word_t(fir_dsp_pkg::coef_t)) tap_store_i (
        .axis_clk, .axis_rst_n, .we(coef_we), .waddr(coef_wr.index[IDX_W-1:0]),
        .wdata(coef_wr.value), .raddr(coef_raddr), .rdata(coef_rdata)
    );

    fir_word_store #(.DEPTH(N_TAPS), .word_t(fir_dsp_pkg::sample_t)) hist_store_i (
        .axis_clk, .axis_rst_n, .we(hist_we), .waddr(hist_waddr),
        .wdata(hist_wdata), .raddr(hist_raddr), .rdata(hist_rdata)
    );

    fir_mac_execute #(.N_TAPS(N_TAPS)) fir_mac_execute_i (
        .axis_clk, .axis_rst_n, .start, .data_len,
        .ss_tvalid, .ss_tdata, .ss_tready,
        .hist_we, .hist_waddr, .hist_wdata, .hist_raddr, .hist_rdata,
        .coef_raddr, .coef_rdata, .res_valid, .res, .res_ready
    );

    fir_result_stream fir_result_stream_i (
        .axis_clk, .axis_rst_n, .res_valid, .res, .res_ready,
        .sm_tvalid, .sm_tdata, .sm_tlast, .sm_tready, .run_done
    );

endmodule

// File: dv/fir_assert.sv
`timescale 1ns/1ps

module fir_assert (
    input logic        axis_clk,
    input logic        axis_rst_n,
    input logic        awvalid,
    input logic        wvalid,
    input logic        awready,
    input logic        wready,
    input logic        ss_tready,
    input logic        ap_idle,
    input logic        sm_tvalid,
    input logic        sm_tready,
    input logic [31:0] sm_tdata
);

    // output word held until taken
    a_sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
        else $error("sm_tvalid dropped or sm_tdata changed before sm_tready");

    // ack pulse only as the answer to a write
    a_ack_pair: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (awready || wready) |-> awready && wready && $past(awvalid && wvalid))
        else $error("awready and wready not paired or not following a write");

    a_idle_no_input: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        ap_idle |-> !ss_tready)
        else $error("ss_tready high while ap_idle is high");

endmodule

bind fir_top fir_assert fir_assert_i (.*);

// File: dv/fir_checker.sv
`timescale 1ns/1ps

module fir_checker #(
    parameter int N_TAPS = 11
) (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic [8*16-1:0]         test_name,
    input  logic [N_TAPS-1:0][31:0] coefs,     // model of the written taps
    input  logic [31:0]             run_len,
    input  logic                    ss_tvalid,
    input  logic                    ss_tready,
    input  logic [31:0]             ss_tdata,
    input  logic                    sm_tvalid,
    input  logic                    sm_tready,
    input  logic [31:0]             sm_tdata,
    input  logic                    sm_tlast,
    input  logic                    awready,
    input  logic                    wready,
    input  logic                    ap_idle,
    output int                      errors
);

    int          err_cnt   = 0;
    int          outputs   = 0;      // results seen this run
    logic        idle_prev = 1'b1;
    logic        ack_prev  = 1'b0;
    int          hist [$];           // samples of this run in arrival order
    logic [32:0] expect_q [$];       // {last, value}

    assign errors = err_cnt;

    // handshake signals settled at mid-cycle
    always @(negedge axis_clk) begin
        int          sum;
        logic [32:0] exp_item;
        if (!axis_rst_n) begin
            if (!ap_idle || ss_tready || sm_tvalid || sm_tlast || awready || wready) begin
                $display("error: outputs are not at their reset values during reset");
                err_cnt++;
            end
        end else begin
            if (awready && ack_prev) begin
                $display("error: write acknowledged on two cycles in a row in %0s", test_name);
                err_cnt++;
            end
            if (ss_tvalid && ss_tready) begin
                if (hist.size() >= run_len) begin
                    $display("error: sample accepted beyond the data length in %0s", test_name);
                    err_cnt++;
                end
                hist.push_back(int'(ss_tdata));
                sum = 0;   // terms before the run stay out of the sum
                for (int i = 0; i < N_TAPS && i < hist.size(); i++) begin
                    sum += int'(coefs[i]) * hist[hist.size() - 1 - i];
                end
                expect_q.push_back({hist.size() == run_len, sum});
            end
            if (sm_tvalid && sm_tready) begin
                outputs++;
                if (expect_q.size() == 0) begin
                    $display("error: output %0d of %0s has no matching sample", outputs,
                             test_name);
                    err_cnt++;
                end else begin
                    exp_item = expect_q.pop_front();
                    if (sm_tdata !== exp_item[31:0]) begin
                        $display("FAILED %0s output %0d: expected %0d actual %0d", test_name,
                                 outputs, $signed(exp_item[31:0]), $signed(sm_tdata));
                        err_cnt++;
                    end
                    if (sm_tlast !== exp_item[32]) begin
                        $display("FAILED %0s tlast of output %0d: expected %0b actual %0b",
                                 test_name, outputs, exp_item[32], sm_tlast);
                        err_cnt++;
                    end
                end
            end
            if (ap_idle && !idle_prev && outputs != run_len) begin
                $display("FAILED %0s output count: expected %0d actual %0d", test_name,
                         run_len, outputs);
                err_cnt++;
            end
            if (ap_idle) begin
                hist.delete();   // next run starts from empty history
                outputs = 0;
            end
        end
        ack_prev  = awready;
        idle_prev = ap_idle;
    end

endmodule

// File: dv/fir_tb.sv
`timescale 1ns/1ps

module fir_tb;

    localparam int N_TAPS  = 11;
    localparam int TIMEOUT = 2000;   // cycles allowed per wait
    localparam int N_ROWS  = 4;

    // one row of the stimulus table
    typedef struct packed {
        logic [8*16-1:0] name;
        logic [31:0]     len;
        logic [1:0]      pattern;     // 0 ramp, 1 random, 2 falling
        logic [6:0]      stall_pct;   // chance of sm_tready low per cycle
        logic            wr_in_run;
    } row_t;

    localparam row_t TESTS [N_ROWS] = '{
        '{128'("ramp_basic"),   32'd20, 2'd0, 7'd0,  1'b0},
        '{128'("stall_random"), 32'd30, 2'd1, 7'd40, 1'b0},
        '{128'("write_in_run"), 32'd16, 2'd1, 7'd20, 1'b1},
        '{128'("second_short"), 32'd5,  2'd2, 7'd10, 1'b0}
    };

    logic                              axis_clk = 1'b0;
    logic                              axis_rst_n;
    logic                              awvalid;
    logic [fir_regmap_pkg::ADDR_W-1:0] awaddr;
    logic                              awready;
    logic                              wvalid;
    logic [31:0]                       wdata;
    logic                              wready;
    logic                              ss_tvalid;
    fir_dsp_pkg::sample_t              ss_tdata;
    logic                              ss_tready;
    logic                              sm_tvalid;
    fir_dsp_pkg::acc_t                 sm_tdata;
    logic                              sm_tlast;
    logic                              sm_tready;
    logic                              ap_idle;
    logic [8*16-1:0]                   test_name;
    logic [N_TAPS-1:0][31:0]           coefs;        // taps in place at start
    logic [31:0]                       run_len;
    logic [31:0]                       rng = 32'h7cb6ca86;
    fir_dsp_pkg::sample_t              samples [$];
    logic                              stop_stall;
    int                                chk_errors;
    int                                timeouts = 0;

    always #4 axis_clk = ~axis_clk;

    fir_top #(.N_TAPS(N_TAPS)) fir_top_i (.*);

    fir_checker #(.N_TAPS(N_TAPS)) fir_checker_i (
        .axis_clk, .axis_rst_n, .test_name, .coefs, .run_len,
        .ss_tvalid, .ss_tready, .ss_tdata, .sm_tvalid, .sm_tready, .sm_tdata,
        .sm_tlast, .awready, .wready, .ap_idle, .errors(chk_errors)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic lite_write(input logic [11:0] addr, input logic [31:0] data);
        int waited;
        waited  = 0;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        @(negedge axis_clk);
        while (!(awready && wready) && waited < TIMEOUT) begin
            @(negedge axis_clk);
            waited++;
        end
        if (!(awready && wready)) begin
            $display("timeout: write to address 0x%h was never acknowledged", addr);
            timeouts++;
        end
        @(posedge axis_clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic feed_samples();
        int waited;
        for (int k = 0; k < samples.size(); k++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = samples[k];
            waited    = 0;
            @(negedge axis_clk);
            while (!ss_tready && waited < TIMEOUT) begin
                @(negedge axis_clk);
                waited++;
            end
            if (!ss_tready) begin
                $display("timeout: sample %0d of %0s was not accepted", k, test_name);
                timeouts++;
                break;
            end
            @(posedge axis_clk);
            #1;
        end
        ss_tdata = 32'h5a5a5a5a;   // offered past the data length and never taken
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge axis_clk);
        while (!ap_idle && waited < TIMEOUT) begin
            @(negedge axis_clk);
            waited++;
        end
        if (!ap_idle) begin
            $display("timeout: ap_idle did not return after the run of %0s", test_name);
            timeouts++;
        end
    endtask

    task automatic drive_stalls(input int pct);
        int cycles;
        cycles = 0;
        while (!stop_stall && cycles < 4 * TIMEOUT) begin
            rng       = lcg_next(rng);
            sm_tready = (rng[31:16] % 100) >= pct;
            @(posedge axis_clk);
            #1;
            cycles++;
        end
        if (!stop_stall) begin
            $display("timeout: run of %0s still busy after the stall window", test_name);
            timeouts++;
        end
        sm_tready = 1'b1;
    endtask

    task automatic run_row(input row_t row);
        test_name = row.name;
        run_len   = row.len;
        samples.delete();
        for (int i = 0; i < N_TAPS; i++) begin
            rng = lcg_next(rng);
            case (row.pattern)
                2'd0:    coefs[i] = i + 1;
                2'd1:    coefs[i] = rng;
                default: coefs[i] = 7 - 3 * i;
            endcase
            lite_write(12'(fir_regmap_pkg::ADDR_TAP_BASE + 4 * i), coefs[i]);
        end
        lite_write(fir_regmap_pkg::ADDR_LEN, row.len);
        for (int k = 0; k < row.len; k++) begin
            rng = lcg_next(rng);
            samples.push_back(rng);
        end
        stop_stall = 1'b0;
        lite_write(fir_regmap_pkg::ADDR_CTRL, 32'd1 << fir_regmap_pkg::CTRL_START_BIT);
        fork
            begin
                feed_samples();
                wait_idle();
                stop_stall = 1'b1;
            end
            drive_stalls(row.stall_pct);
            if (row.wr_in_run) begin
                repeat (3 * N_TAPS) @(posedge axis_clk);   // well inside the run
                #1;
                lite_write(fir_regmap_pkg::ADDR_TAP_BASE, 32'h0badcafe);
                lite_write(fir_regmap_pkg::ADDR_LEN, 32'd3);
            end
        join
        repeat (4) @(posedge axis_clk);
        #1;
        ss_tvalid = 1'b0;
    endtask

    initial begin
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b1;
        stop_stall = 1'b0;
        test_name  = 128'("reset");
        coefs      = '0;
        run_len    = '0;
        repeat (8) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(TESTS[r]);
        end
        $display("errors: checks %0d, timeouts %0d", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
source/fir_regmap_pkg.sv
source/fir_dsp_pkg.sv
source/fir_word_store.sv
source/fir_ctrl_decode.sv
source/fir_mac_execute.sv
source/fir_result_stream.sv
source/fir_top.sv
dv/fir_assert.sv
dv/fir_checker.sv
dv/fir_tb.sv

// File: Makefile
# Verilator build and run of the FIR testbench

VERILATOR ?= verilator
TOP       ?= fir_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
